// File: dv/pdu_tb.sv
`default_nettype none
`include "pdu_consts.svh"

module pdu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PKTS        = 24;
    localparam int PKT_ADMIT_LIMIT = `PKT_BUF_DEPTH - 2 - `MAX_PKT_FLITS;
    // the model also counts the descriptor still in flight at admission time
    localparam int DESC_ADMIT_MAX  = `DESC_BUF_DEPTH - 3;
    localparam int STALL_CYCLES    = 40;

    logic                    clk;
    logic                    rst;
    logic                    in_sop;
    logic                    in_eop;
    logic [`PDU_DATA_W-1:0]  in_data;
    logic [`PDU_EMPTY_W-1:0] in_empty;
    logic                    in_valid;
    logic                    in_ready;
    logic                    in_meta_valid;
    pdu_pkg::metadata_t      in_meta_data;
    logic                    in_meta_ready;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [7:0]              wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;

    logic [15:0]             lfsr;
    int                      pkt_len [NUM_PKTS];
    int                      pkt_empty [NUM_PKTS];
    logic [15:0]             pkt_qid [NUM_PKTS];
    pdu_pkg::flit_t          exp_flits [$];
    pdu_pkg::pkt_desc_t      exp_descs [$];
    string                   cmp_name [$];
    logic [31:0]             cmp_got [$];
    logic [31:0]             cmp_exp [$];
    int                      error_count;
    int                      check_count;
    int                      cycle_count;
    int                      cycle_limit;
    int                      flits_acc;
    int                      eops_seen;
    int                      meta_pulses;
    int                      flits_popped;
    int                      descs_popped;
    logic                    ready_q;
    logic                    stim_go;
    logic                    stim_done;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    pdu_subsys_top dut (
        .clk           (clk),
        .rst           (rst),
        .in_sop        (in_sop),
        .in_eop        (in_eop),
        .in_data       (in_data),
        .in_empty      (in_empty),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_meta_valid (in_meta_valid),
        .in_meta_data  (in_meta_data),
        .in_meta_ready (in_meta_ready),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

    // ********************
    // random source and reference
    // ********************

    function automatic logic [31:0] next_random(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // host byte order puts input byte 0 at byte 63
    function automatic pdu_pkg::flit_t reverse_flit(input logic [`PDU_DATA_W-1:0] data,
                                                    input logic sop, input logic eop);
        pdu_pkg::flit_t f;
        for (int i = 0; i < 64; i++) begin
            f.data[i*8 +: 8] = data[(63 - i)*8 +: 8];
        end
        f.sop = sop;
        f.eop = eop;
        return f;
    endfunction

    function automatic pdu_pkg::pkt_desc_t expected_desc(input logic [15:0] qid, input int flits,
                                                         input int empty, input int id);
        pdu_pkg::pkt_desc_t d;
        int bytes;
        bytes      = 64 * flits - empty;
        d.queue_id = qid[`APP_IDX_W-1:0];
        d.flits    = flits[15:0];
        d.bytes    = bytes[15:0];
        d.pdu_id   = id[15:0];
        return d;
    endfunction

    task automatic plan_packets();
        int total;
        total = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_len[p]   = int'(next_random(4)) + 1;
            pkt_empty[p] = int'(next_random(6));
            pkt_qid[p]   = 16'(next_random(16));
            total        = total + pkt_len[p];
        end
        // make sure both size extremes appear
        total        = total - pkt_len[0] - pkt_len[1] + 1 + `MAX_PKT_FLITS;
        pkt_len[0]   = 1;
        pkt_len[1]   = `MAX_PKT_FLITS;
        cycle_limit  = 40 * total + 200 * NUM_PKTS;
    endtask

    // ********************
    // input stream
    // ********************

    task automatic send_packets();
        logic [`PDU_DATA_W-1:0] data;
        int gap;
        wait (stim_go);
        for (int p = 0; p < NUM_PKTS; p++) begin
            in_meta_valid         = 1'b1;
            in_meta_data.queue_id = pkt_qid[p];
            for (int f = 0; f < pkt_len[p]; f++) begin
                gap      = int'(next_random(2));
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
                for (int w = 0; w < `PDU_DATA_W / 32; w++) begin
                    data[w*32 +: 32] = next_random(32);
                end
                in_valid = 1'b1;
                in_sop   = (f == 0);
                in_eop   = (f == pkt_len[p] - 1);
                in_empty = in_eop ? pkt_empty[p][`PDU_EMPTY_W-1:0] : '0;
                in_data  = data;
                exp_flits.push_back(reverse_flit(data, in_sop, in_eop));
                while (!in_ready) @(negedge clk);
                @(negedge clk);
            end
            in_valid = 1'b0;
            in_sop   = 1'b0;
            in_eop   = 1'b0;
            exp_descs.push_back(expected_desc(pkt_qid[p], pkt_len[p], pkt_empty[p], p));
            // hold the metadata item until the generator consumes it
            while (!in_meta_ready) @(negedge clk);
            @(negedge clk);
            in_meta_valid = 1'b0;
        end
        stim_done = 1'b1;
    endtask

    // ********************
    // host side
    // ********************

    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        int latency;
        // a request raised during the previous ack cycle is only seen once ack has dropped
        latency  = wb_ack ? 2 : 1;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack);
        check_count++;
        if (waited != latency) begin
            error_count++;
            $display("wb_ack came %0d cycles after the request instead of %0d",
                     waited, latency);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        cmp_name.push_back(name);
        cmp_got.push_back(got);
        cmp_exp.push_back(exp);
    endtask

    task automatic run_host();
        logic [31:0]        rd;
        logic [31:0]        status;
        pdu_pkg::pkt_desc_t d;
        pdu_pkg::flit_t     ef;
        int                 stall;
        int                 done;
        repeat (20) begin
            @(negedge clk);
            check_count++;
            if (in_ready) begin
                error_count++;
                $display("in_ready went high with no metadata offered");
            end
        end
        bus_access(1'b0, 8'd0, 32'd0, rd);
        expect_word("status word after reset", rd, 32'd0);
        stim_go = 1'b1;

        // leave the buffers unread until the input has to stop
        stall = 0;
        while (stall < STALL_CYCLES && !stim_done) begin
            @(negedge clk);
            stall = (in_meta_valid && !in_ready) ? stall + 1 : 0;
        end
        check_count++;
        if (stall < STALL_CYCLES) begin
            error_count++;
            $display("input never stalled although the host did not pop");
        end else if ((flits_acc - flits_popped) < PKT_ADMIT_LIMIT &&
                     (eops_seen - descs_popped) < DESC_ADMIT_MAX) begin
            error_count++;
            $display("input stalled while both buffers still had room");
        end
        status = 32'(((flits_acc - flits_popped) << 16) | (eops_seen - descs_popped));
        bus_access(1'b0, 8'd0, 32'd0, rd);
        expect_word("status word under back-pressure", rd, status);

        done = 0;
        while (done < NUM_PKTS) begin
            bus_access(1'b0, 8'd0, 32'd0, rd);
            if (rd[`DESC_BUF_AW-1:0] == '0) begin
                repeat (4) @(negedge clk);
            end else if (exp_descs.size() == 0) begin
                error_count++;
                $display("descriptor buffer holds an entry that was never sent");
                done = NUM_PKTS;
            end else begin
                d = exp_descs.pop_front();
                bus_access(1'b0, 8'd1, 32'd0, rd);
                expect_word("descriptor queue_id/flits", rd, {d.flits, 12'h000, d.queue_id});
                bus_access(1'b0, 8'd2, 32'd0, rd);
                expect_word("descriptor bytes/pdu_id", rd, {d.pdu_id, d.bytes});
                bus_access(1'b1, 8'd4, 32'd0, rd);
                descs_popped++;
                for (int f = 0; f < int'(d.flits); f++) begin
                    ef = exp_flits.pop_front();
                    bus_access(1'b0, 8'd3, 32'd0, rd);
                    expect_word("flit sop/eop", rd, {30'd0, ef.eop, ef.sop});
                    for (int w = 0; w < 16; w++) begin
                        bus_access(1'b0, 8'(16 + w), 32'd0, rd);
                        expect_word($sformatf("flit data word %0d", w), rd, ef.data[w*32 +: 32]);
                    end
                    bus_access(1'b1, 8'd5, 32'd0, rd);
                    flits_popped++;
                end
                done++;
            end
        end
        bus_access(1'b0, 8'd0, 32'd0, rd);
        expect_word("status word after draining", rd, 32'd0);
    endtask

    // ********************
    // compare and monitor
    // ********************

    always @(negedge clk) begin
        while (cmp_got.size() > 0) begin
            check_count++;
            if (cmp_got[0] !== cmp_exp[0]) begin
                error_count++;
                $display("FAILED wb_dat_r (%s): got 0x%08h, expected 0x%08h",
                         cmp_name[0], cmp_got[0], cmp_exp[0]);
            end
            void'(cmp_name.pop_front());
            void'(cmp_got.pop_front());
            void'(cmp_exp.pop_front());
        end
    end

    // sampled at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (!rst) begin
            if (in_ready && !ready_q) begin
                check_count++;
                if ((flits_acc - flits_popped) >= PKT_ADMIT_LIMIT ||
                    (eops_seen - descs_popped) > DESC_ADMIT_MAX) begin
                    error_count++;
                    $display("packet admitted with %0d flits and %0d descriptors buffered",
                             flits_acc - flits_popped, eops_seen - descs_popped);
                end
            end
            if (in_valid && in_ready) begin
                flits_acc++;
                if (in_eop) begin
                    eops_seen++;
                end
            end
            if (in_meta_ready) begin
                check_count++;
                if (meta_pulses >= eops_seen) begin
                    error_count++;
                    $display("in_meta_ready pulsed with no new end-of-packet flit accepted");
                end
                meta_pulses++;
            end
        end
        ready_q = in_ready;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        in_sop        = 1'b0;
        in_eop        = 1'b0;
        in_data       = '0;
        in_empty      = '0;
        in_valid      = 1'b0;
        in_meta_valid = 1'b0;
        in_meta_data  = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        lfsr          = 16'd50668;
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        flits_acc     = 0;
        eops_seen     = 0;
        meta_pulses   = 0;
        flits_popped  = 0;
        descs_popped  = 0;
        ready_q       = 1'b0;
        stim_go       = 1'b0;
        stim_done     = 1'b0;
        plan_packets();
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        fork
            send_packets();
            run_host();
        join
        repeat (2) @(negedge clk);
        check_count++;
        if (meta_pulses != NUM_PKTS || eops_seen != NUM_PKTS) begin
            error_count++;
            $display("saw %0d metadata pulses for %0d packets", meta_pulses, eops_seen);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset is released on a falling edge so the DUT sees it cleanly
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/pdu_pkg.sv
rtl/pdu_fifo.sv
rtl/pdu_gen.sv
rtl/host_wb_port.sv
rtl/pdu_subsys_top.sv
dv/tb_clock.sv
dv/pdu_tb.sv

// File: rtl/host_wb_port.sv
`default_nettype none
`include "pdu_consts.svh"

module host_wb_port (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [7:0]              wb_adr,
    input  wire logic [31:0]             wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    input  wire pdu_pkg::flit_t          pkt_head,
    input  wire logic [`PKT_BUF_AW-1:0]  pkt_occup,
    input  wire logic                    pkt_empty,
    output logic                         pkt_rd_en,
    input  wire pdu_pkg::pkt_desc_t      desc_head,
    input  wire logic [`DESC_BUF_AW-1:0] desc_occup,
    input  wire logic                    desc_empty,
    output logic                         desc_rd_en
);

    localparam logic [7:0] ADR_STATUS   = 8'd0;
    localparam logic [7:0] ADR_DESC_LO  = 8'd1;
    localparam logic [7:0] ADR_DESC_HI  = 8'd2;
    localparam logic [7:0] ADR_FLIT_CTL = 8'd3;
    localparam logic [7:0] ADR_POP_DESC = 8'd4;
    localparam logic [7:0] ADR_POP_FLIT = 8'd5;

    logic        req;
    logic [31:0] rd_word;

    // a new request is one that has not been acknowledged yet
    assign req = wb_cyc && wb_stb && !wb_ack;

    // ********************
    // read decode
    // ********************

    always_comb begin
        rd_word = '0;
        case (wb_adr)
            ADR_STATUS: begin
                rd_word[`DESC_BUF_AW-1:0]  = desc_occup;
                rd_word[16 +: `PKT_BUF_AW] = pkt_occup;
            end
            ADR_DESC_LO: begin
                rd_word[`APP_IDX_W-1:0] = desc_head.queue_id;
                rd_word[31:16]          = desc_head.flits;
            end
            ADR_DESC_HI: begin
                rd_word[15:0]            = desc_head.bytes;
                rd_word[16 +: `PDU_ID_W] = desc_head.pdu_id;
            end
            ADR_FLIT_CTL: begin
                rd_word[0] = pkt_head.sop;
                rd_word[1] = pkt_head.eop;
            end
            default: begin
                // words 16 to 31 window onto the head flit, lowest word first
                if (wb_adr[7:4] == 4'd1) begin
                    rd_word = pkt_head.data[wb_adr[3:0]*32 +: 32];
                end
            end
        endcase
    end

    // ********************
    // ack and pops
    // ********************

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= wb_we ? wb_dat_w : rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            desc_rd_en <= 1'b0;
            pkt_rd_en  <= 1'b0;
        end else begin
            wb_ack     <= req;
            desc_rd_en <= req && wb_we && (wb_adr == ADR_POP_DESC) && !desc_empty;
            pkt_rd_en  <= req && wb_we && (wb_adr == ADR_POP_FLIT) && !pkt_empty;
        end
    end

    // classic cycles without wait states still need ack to drop between transfers
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// File: rtl/pdu_consts.svh
`ifndef PDU_CONSTS_SVH
`define PDU_CONSTS_SVH

// stream widths
`define PDU_DATA_W      512
`define PDU_EMPTY_W     6
`define APP_IDX_W       4

// packet buffer, counted in flits
`define PKT_BUF_DEPTH   64
`define PKT_BUF_AW      7

// descriptor buffer
`define DESC_BUF_DEPTH  16
`define DESC_BUF_AW     5

// largest packet the generator must be able to hold
`define MAX_PKT_FLITS   16
`define PDU_ID_W        16

`endif

// File: rtl/pdu_fifo.sv
`default_nettype none

module pdu_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16,
    parameter int  AW        = 5
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    wr_en,
    input  wire payload_t wr_data,
    input  wire logic    rd_en,
    output payload_t     rd_data,
    output logic [AW-1:0] occup,
    output logic         empty
);

    localparam int PW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [AW-1:0] count;
    logic          full;
    logic          wr_ok;
    logic          rd_ok;

    assign full  = (count == AW'(DEPTH));
    assign empty = (count == '0);
    assign occup = count;
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // the head is read straight from storage
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the writer is expected to reserve room before it starts writing
    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full);

    no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty);

endmodule

`default_nettype wire

// File: rtl/pdu_gen.sv
`default_nettype none
`include "pdu_consts.svh"

module pdu_gen (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    in_sop,
    input  wire logic                    in_eop,
    input  wire logic [`PDU_DATA_W-1:0]  in_data,
    input  wire logic [`PDU_EMPTY_W-1:0] in_empty,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire logic                    in_meta_valid,
    input  wire pdu_pkg::metadata_t      in_meta_data,
    output logic                         in_meta_ready,
    input  wire logic [`PKT_BUF_AW-1:0]  pkt_occup,
    input  wire logic [`DESC_BUF_AW-1:0] desc_occup,
    output logic                         pkt_wr_en,
    output pdu_pkg::flit_t               pkt_wr_data,
    output logic                         desc_wr_en,
    output pdu_pkg::pkt_desc_t           desc_wr_data
);

    typedef enum logic {
        ST_START,
        ST_WRITE
    } state_t;

    state_t                 state;
    logic [15:0]            flit_cnt;
    logic [15:0]            byte_cnt;
    logic [15:0]            flits_next;
    logic [15:0]            bytes_next;
    logic [`PDU_ID_W-1:0]   pdu_id;
    logic [`PDU_DATA_W-1:0] data_rev;
    logic                   accept;
    logic                   room;
    pdu_pkg::pkt_desc_t     desc_pend;

    assign in_ready = (state == ST_WRITE);
    assign accept   = in_valid && in_ready;

    // room for a full-size packet plus the flits and descriptors still in the pipeline
    assign room = (pkt_occup < (`PKT_BUF_DEPTH - 2 - `MAX_PKT_FLITS)) &&
                  (desc_occup < (`DESC_BUF_DEPTH - 3));

    assign flits_next = flit_cnt + 16'd1;
    assign bytes_next = byte_cnt + 16'd64 - (in_eop ? 16'(in_empty) : 16'd0);

    // host byte order: byte 0 of the flit becomes byte 63
    always_comb begin
        for (int i = 0; i < `PDU_DATA_W / 8; i++) begin
            data_rev[i*8 +: 8] = in_data[`PDU_DATA_W - 8 - i*8 +: 8];
        end
    end

    // ********************
    // admission FSM
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_START;
            flit_cnt      <= '0;
            byte_cnt      <= '0;
            pdu_id        <= '0;
            in_meta_ready <= 1'b0;
        end else begin
            in_meta_ready <= 1'b0;
            case (state)
                ST_START: begin
                    flit_cnt <= '0;
                    byte_cnt <= '0;
                    // the pending consume pulse still refers to the previous packet's item
                    if (in_meta_valid && !in_meta_ready && room) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (accept) begin
                        flit_cnt <= flits_next;
                        byte_cnt <= bytes_next;
                        if (in_eop) begin
                            in_meta_ready <= 1'b1;
                            pdu_id        <= pdu_id + 1'b1;
                            state         <= ST_START;
                        end
                    end
                end
                default: state <= ST_START;
            endcase
        end
    end

    // ********************
    // buffer writes
    // ********************

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_wr_data.data <= data_rev;
            pkt_wr_data.sop  <= in_sop;
            pkt_wr_data.eop  <= in_eop;
        end
        if (accept && in_eop) begin
            desc_pend.queue_id <= in_meta_data.queue_id[`APP_IDX_W-1:0];
            desc_pend.flits    <= flits_next;
            desc_pend.bytes    <= bytes_next;
            desc_pend.pdu_id   <= pdu_id;
        end
        if (in_meta_ready) begin
            desc_wr_data <= desc_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_wr_en  <= 1'b0;
            desc_wr_en <= 1'b0;
        end else begin
            pkt_wr_en  <= accept;
            desc_wr_en <= in_meta_ready;
        end
    end

    // the source must mark the first flit of every packet and no other
    sop_on_first_flit: assert property (@(posedge clk) disable iff (rst)
        accept |-> (in_sop == (flit_cnt == 16'd0)));

    // the admission margin only covers packets up to the maximum size
    pkt_within_max: assert property (@(posedge clk) disable iff (rst)
        accept |-> (flit_cnt < 16'(`MAX_PKT_FLITS)));

endmodule

`default_nettype wire

// File: rtl/pdu_pkg.sv
`default_nettype none
`include "pdu_consts.svh"

package pdu_pkg;

    // ********************
    // stream payloads
    // ********************

    // one flit as stored in the packet buffer, already in host byte order
    typedef struct packed {
        logic [`PDU_DATA_W-1:0] data;
        logic                   sop;
        logic                   eop;
    } flit_t;

    // only the low APP_IDX_W bits of queue_id are meaningful
    typedef struct packed {
        logic [15:0] queue_id;
    } metadata_t;

    // ********************
    // descriptor
    // ********************

    typedef struct packed {
        logic [`APP_IDX_W-1:0] queue_id;
        logic [15:0]           flits;
        logic [15:0]           bytes;
        logic [`PDU_ID_W-1:0]  pdu_id;
    } pkt_desc_t;

endpackage

`default_nettype wire

// File: rtl/pdu_subsys_top.sv
`default_nettype none
`include "pdu_consts.svh"

module pdu_subsys_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    in_sop,
    input  wire logic                    in_eop,
    input  wire logic [`PDU_DATA_W-1:0]  in_data,
    input  wire logic [`PDU_EMPTY_W-1:0] in_empty,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire logic                    in_meta_valid,
    input  wire pdu_pkg::metadata_t      in_meta_data,
    output logic                         in_meta_ready,
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [7:0]              wb_adr,
    input  wire logic [31:0]             wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack
);

    logic                    pkt_wr_en;
    pdu_pkg::flit_t          pkt_wr_data;
    logic                    pkt_rd_en;
    pdu_pkg::flit_t          pkt_head;
    logic [`PKT_BUF_AW-1:0]  pkt_occup;
    logic                    pkt_empty;
    logic                    desc_wr_en;
    pdu_pkg::pkt_desc_t      desc_wr_data;
    logic                    desc_rd_en;
    pdu_pkg::pkt_desc_t      desc_head;
    logic [`DESC_BUF_AW-1:0] desc_occup;
    logic                    desc_empty;

    pdu_gen u_pdu_gen (
        .clk           (clk),
        .rst           (rst),
        .in_sop        (in_sop),
        .in_eop        (in_eop),
        .in_data       (in_data),
        .in_empty      (in_empty),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_meta_valid (in_meta_valid),
        .in_meta_data  (in_meta_data),
        .in_meta_ready (in_meta_ready),
        .pkt_occup     (pkt_occup),
        .desc_occup    (desc_occup),
        .pkt_wr_en     (pkt_wr_en),
        .pkt_wr_data   (pkt_wr_data),
        .desc_wr_en    (desc_wr_en),
        .desc_wr_data  (desc_wr_data)
    );

    pdu_fifo #(
        .payload_t (pdu_pkg::flit_t),
        .DEPTH     (`PKT_BUF_DEPTH),
        .AW        (`PKT_BUF_AW)
    ) pkt_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (pkt_wr_en),
        .wr_data (pkt_wr_data),
        .rd_en   (pkt_rd_en),
        .rd_data (pkt_head),
        .occup   (pkt_occup),
        .empty   (pkt_empty)
    );

    pdu_fifo #(
        .payload_t (pdu_pkg::pkt_desc_t),
        .DEPTH     (`DESC_BUF_DEPTH),
        .AW        (`DESC_BUF_AW)
    ) desc_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (desc_wr_en),
        .wr_data (desc_wr_data),
        .rd_en   (desc_rd_en),
        .rd_data (desc_head),
        .occup   (desc_occup),
        .empty   (desc_empty)
    );

    host_wb_port u_host_wb_port (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .pkt_head   (pkt_head),
        .pkt_occup  (pkt_occup),
        .pkt_empty  (pkt_empty),
        .pkt_rd_en  (pkt_rd_en),
        .desc_head  (desc_head),
        .desc_occup (desc_occup),
        .desc_empty (desc_empty),
        .desc_rd_en (desc_rd_en)
    );

endmodule

`default_nettype wire
